// File: tinyPipe_macros.svh
`default_nettype none

`ifndef TINYPIPE_MACROS_SVH
`define TINYPIPE_MACROS_SVH

// datapath width, shared by registers, memory data and instruction words
`define DATA_W 16

// register file depth, r0 is hardwired to zero
`define REG_N 8

// byte address width of fetch and data accesses
`define PC_W 16

// all-zero word decodes as NOP, used for bubbles and flushes
`define INSTR_NOP {`DATA_W{1'b0}}

`endif

`default_nettype wire

// File: tinyPipePkg.sv
`include "tinyPipe_macros.svh"
`default_nettype none

package tinyPipePkg;

	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,		// must stay zero, matches INSTR_NOP
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SHL  = 4'd6,		// shift by low bits of rb
		OP_ADDI = 4'd7,		// ra + imm6
		OP_LD   = 4'd8,		// rd = mem[ra + imm6]
		OP_ST   = 4'd9,		// mem[ra + imm6] = rd
		OP_BEQZ = 4'd10,	// branch by imm6 words if rd == 0
		OP_BRA  = 4'd11,	// branch by imm9 words
		OP_HALT = 4'd12		// highest legal opcode
	} opCode;

	typedef enum logic [1:0] {
		OK_READY = 2'd0,	// port idle
		OK_OK    = 2'd1,	// request done
		OK_HOLD  = 2'd2		// request must stay put
	} okCode;

	typedef enum logic [1:0] {
		MEM_IDLE  = 2'd0,
		MEM_FETCH = 2'd1,
		MEM_LOAD  = 2'd2,
		MEM_STORE = 2'd3
	} memMode;

	typedef logic [$clog2(`REG_N)-1:0] regIdx;	// register number

	// decode to execute payload
	typedef struct packed {
		opCode op;
		regIdx rd;
		regIdx ra;
		regIdx rb;			// holds rd for ST and BEQZ
		logic [`DATA_W-1:0] imm;	// already sign extended
		logic [`PC_W-1:0] pc;		// address of this instruction
		logic [`DATA_W-1:0] raVal;
		logic [`DATA_W-1:0] rbVal;
		logic writesReg;
	} decodedOp;

	// execute to result payload
	typedef struct packed {
		logic writesReg;
		regIdx rd;
		logic [`DATA_W-1:0] value;
	} resultOp;

endpackage

`default_nettype wire

// File: pipeStage.sv
`timescale 1ns/1ps
`default_nettype none

// generic stage register, one instance per payload type
module pipeStage #(
	parameter type payloadT = logic,
	parameter payloadT bubble = '0		// value loaded on reset and flush
) (
	input logic clock,
	input logic rst,
	input logic hold,		// freeze, q keeps its value
	input logic flush,		// replace the next payload with a bubble
	input payloadT d,
	output payloadT q
);

	always_ff @(posedge clock)
	begin
		if (rst || flush)
		begin
			q <= bubble;	// kills whatever sits in d
		end
		else if (!hold)
		begin
			q <= d;		// normal advance
		end
		// held: nothing moves
	end

endmodule

`default_nettype wire

// File: instrDecode.sv
`timescale 1ns/1ps
`include "tinyPipe_macros.svh"
`default_nettype none

module instrDecode (
	input logic [`DATA_W-1:0] instr,		// word from the fetch register
	input logic [`PC_W-1:0] pc,			// its address
	output tinyPipePkg::regIdx raAddr,
	output tinyPipePkg::regIdx rbAddr,
	input logic [`DATA_W-1:0] raVal,		// from the register file
	input logic [`DATA_W-1:0] rbVal,
	output tinyPipePkg::decodedOp decoded
);
	import tinyPipePkg::*;

	opCode op;
	regIdx rd;
	logic readsRd;		// rd is a source, not a target

	// opcodes 13..15 are unused and run as NOP
	assign op = (instr[15:12] > OP_HALT) ? OP_NOP : opCode'(instr[15:12]);
	assign rd = instr[11:9];
	assign readsRd = (op == OP_ST) || (op == OP_BEQZ);

	assign raAddr = instr[8:6];
	assign rbAddr = readsRd ? rd : instr[5:3];	// rd goes out on the rb port

	always_comb
	begin
		decoded.op = op;
		decoded.rd = rd;
		decoded.ra = raAddr;
		decoded.rb = rbAddr;		// forwarding compares against this
		decoded.pc = pc;
		decoded.raVal = raVal;
		decoded.rbVal = rbVal;

		if (op == OP_BRA)
		begin
			decoded.imm = {{(`DATA_W-9){instr[8]}}, instr[8:0]};	// imm9
		end
		else
		begin
			decoded.imm = {{(`DATA_W-6){instr[5]}}, instr[5:0]};	// imm6
		end

		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_ADDI, OP_LD:
			begin
				decoded.writesReg = 1'b1;
			end
			default:
			begin
				decoded.writesReg = 1'b0;	// stores, branches, NOP, HALT
			end
		endcase
	end

endmodule

`default_nettype wire

// File: execUnit.sv
`timescale 1ns/1ps
`include "tinyPipe_macros.svh"
`default_nettype none

module execUnit (
	input logic clock,
	input logic rst,
	input logic hold,
	input tinyPipePkg::decodedOp op,		// from the execute stage register
	input tinyPipePkg::regIdx wbRd,		// result stage, one instruction older
	input logic [`DATA_W-1:0] wbValue,
	input logic wbWrite,
	output tinyPipePkg::memMode dataMode,
	output logic [`PC_W-1:0] dataAddr,		// byte address
	output logic [`DATA_W-1:0] dataWrData,
	input logic [`DATA_W-1:0] dataRdData,
	input tinyPipePkg::okCode dataOk,
	output tinyPipePkg::resultOp result,
	output logic branchTaken,
	output logic [`PC_W-1:0] branchTarget,
	output logic halted		// sticky until reset
);
	import tinyPipePkg::*;

	localparam int SHIFT_W = $clog2(`DATA_W);

	logic [`DATA_W-1:0] aVal;
	logic [`DATA_W-1:0] bVal;
	logic [`DATA_W-1:0] aluOut;
	logic [`DATA_W-1:0] effAddr;		// word index of LD/ST

	// bypass from the result stage, r0 never forwarded
	assign aVal = (wbWrite && wbRd == op.ra && op.ra != '0) ? wbValue : op.raVal;
	assign bVal = (wbWrite && wbRd == op.rb && op.rb != '0) ? wbValue : op.rbVal;

	always_comb
	begin
		case (op.op)
			OP_ADD: aluOut = aVal + bVal;
			OP_SUB: aluOut = aVal - bVal;
			OP_AND: aluOut = aVal & bVal;
			OP_OR: aluOut = aVal | bVal;
			OP_XOR: aluOut = aVal ^ bVal;
			OP_SHL: aluOut = aVal << bVal[SHIFT_W-1:0];
			OP_ADDI: aluOut = aVal + op.imm;
			default: aluOut = '0;
		endcase
	end

	// memory holds 16-bit words, so the word index becomes a byte address
	assign effAddr = aVal + op.imm;
	assign dataAddr = `PC_W'({effAddr, 1'b0});
	assign dataWrData = bVal;		// ST source is rd, read on the rb port

	always_comb
	begin
		if (halted)
		begin
			dataMode = MEM_IDLE;		// nothing issues past HALT
		end
		else if (op.op == OP_LD)
		begin
			dataMode = MEM_LOAD;
		end
		else if (op.op == OP_ST)
		begin
			dataMode = MEM_STORE;
		end
		else
		begin
			dataMode = MEM_IDLE;
		end
	end

	always_comb
	begin
		result.rd = op.rd;
		result.value = (op.op == OP_LD) ? dataRdData : aluOut;
		// a load only writes once the data came back
		result.writesReg = op.writesReg && !halted && (op.op != OP_LD || dataOk == OK_OK);
	end

	// branch offsets count words from the branch's own address
	assign branchTarget = op.pc + `PC_W'({op.imm, 1'b0});
	assign branchTaken = !halted && ((op.op == OP_BRA) || (op.op == OP_BEQZ && bVal == '0));

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			halted <= 1'b0;
		end
		else if (!hold && op.op == OP_HALT)
		begin
			halted <= 1'b1;		// stays until the next reset
		end
	end

endmodule

`default_nettype wire

// File: resultRegs.sv
`timescale 1ns/1ps
`include "tinyPipe_macros.svh"
`default_nettype none

module resultRegs (
	input logic clock,
	input logic rst,
	input logic hold,
	input tinyPipePkg::resultOp res,		// from the result stage register
	input tinyPipePkg::regIdx raAddr,		// decode read ports
	input tinyPipePkg::regIdx rbAddr,
	output logic [`DATA_W-1:0] raVal,
	output logic [`DATA_W-1:0] rbVal
);

	logic [`DATA_W-1:0] regs [`REG_N];
	logic wrEn;

	// r0 is never written, held cycles write nothing
	assign wrEn = res.writesReg && !hold && res.rd != '0;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < `REG_N; i++)
			begin
				regs[i] <= '0;		// program starts from all-zero registers
			end
		end
		else if (wrEn)
		begin
			regs[res.rd] <= res.value;
		end
	end

	// write-through, so a reader two slots behind the writer sees the new value
	assign raVal = (raAddr == '0) ? '0 :
		(wrEn && raAddr == res.rd) ? res.value : regs[raAddr];
	assign rbVal = (rbAddr == '0) ? '0 :
		(wrEn && rbAddr == res.rd) ? res.value : regs[rbAddr];

endmodule

`default_nettype wire

// File: memArbiter.sv
`timescale 1ns/1ps
`include "tinyPipe_macros.svh"
`default_nettype none

module memArbiter (
	input logic fetchReq,
	input logic [`PC_W-1:0] fetchAddr,
	output logic [`DATA_W-1:0] fetchData,
	output tinyPipePkg::okCode fetchOk,
	input tinyPipePkg::memMode dataMode,
	input logic [`PC_W-1:0] dataAddr,
	input logic [`DATA_W-1:0] dataWrData,
	output logic [`DATA_W-1:0] dataRdData,
	output tinyPipePkg::okCode dataOk,
	output tinyPipePkg::memMode memMode,		// external port
	output logic [`PC_W-1:0] memAddr,
	output logic [`DATA_W-1:0] memWrData,
	input logic [`DATA_W-1:0] memRdData,
	input tinyPipePkg::okCode memOk
);
	import tinyPipePkg::*;

	// read data goes to both, only the granted side sees OK
	assign fetchData = memRdData;
	assign dataRdData = memRdData;

	always_comb
	begin
		memMode = MEM_IDLE;
		memAddr = '0;
		memWrData = '0;
		fetchOk = OK_HOLD;		// loser waits
		dataOk = OK_HOLD;

		if (dataMode != MEM_IDLE)
		begin
			// execute holds the older instruction, it goes first
			memMode = dataMode;
			memAddr = dataAddr;
			memWrData = dataWrData;
			dataOk = memOk;
		end
		else if (fetchReq)
		begin
			memMode = MEM_FETCH;
			memAddr = fetchAddr;
			fetchOk = memOk;
		end
		else
		begin
			fetchOk = OK_READY;		// nobody asked
			dataOk = OK_READY;
		end
	end

endmodule

`default_nettype wire

// File: tinyPipeTop.sv
`timescale 1ns/1ps
`include "tinyPipe_macros.svh"
`default_nettype none

module tinyPipeTop (
	input logic clock,
	input logic rst,
	output tinyPipePkg::memMode memMode,
	output logic [`PC_W-1:0] memAddr,
	output logic [`DATA_W-1:0] memWrData,
	input logic [`DATA_W-1:0] memRdData,
	input tinyPipePkg::okCode memOk,
	output logic halted
);
	import tinyPipePkg::*;

	logic [`PC_W-1:0] pc;
	logic [`PC_W-1:0] fetchPc;			// address of fetchInstr
	logic [`DATA_W-1:0] fetchInstr;		// fetch register, feeds decode
	logic [`DATA_W-1:0] fetchData;
	logic fetchReq;
	logic started;				// one idle cycle after reset
	okCode fetchOk;
	okCode dataOk;
	tinyPipePkg::memMode dataMode;
	logic [`PC_W-1:0] dataAddr;
	logic [`DATA_W-1:0] dataWrData;
	logic [`DATA_W-1:0] dataRdData;
	regIdx raAddr;
	regIdx rbAddr;
	logic [`DATA_W-1:0] raVal;
	logic [`DATA_W-1:0] rbVal;
	decodedOp decodedNext;
	decodedOp exOp;
	resultOp resultNext;
	resultOp wbOp;
	logic branchTaken;
	logic [`PC_W-1:0] branchTarget;
	logic hold;
	logic flush;

	// only a real memory HOLD stalls, the arbiter's HOLD to fetch is just a bubble
	assign hold = (memOk == OK_HOLD) && (memMode != MEM_IDLE);
	assign flush = branchTaken && !hold;
	assign fetchReq = started && !halted;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			started <= 1'b0;
			pc <= '0;
			fetchInstr <= `INSTR_NOP;
		end
		else
		begin
			started <= 1'b1;
			if (!hold)
			begin
				if (branchTaken)
					pc <= branchTarget;		// redirect wins over the fetch
				else if (fetchOk == OK_OK)
					pc <= pc + `PC_W'(2);
				// flushed or missed fetch turns into a bubble
				fetchInstr <= (branchTaken || fetchOk != OK_OK) ? `INSTR_NOP : fetchData;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			fetchPc <= pc;
	end

	memArbiter memArb (.fetchReq(fetchReq), .fetchAddr(pc), .fetchData(fetchData),
		.fetchOk(fetchOk), .dataMode(dataMode), .dataAddr(dataAddr),
		.dataWrData(dataWrData), .dataRdData(dataRdData), .dataOk(dataOk),
		.memMode(memMode), .memAddr(memAddr), .memWrData(memWrData),
		.memRdData(memRdData), .memOk(memOk));

	instrDecode decode (.instr(fetchInstr), .pc(fetchPc), .raAddr(raAddr),
		.rbAddr(rbAddr), .raVal(raVal), .rbVal(rbVal), .decoded(decodedNext));

	pipeStage #(.payloadT(decodedOp), .bubble('0)) exStage (.clock(clock), .rst(rst),
		.hold(hold), .flush(flush), .d(decodedNext), .q(exOp));	// bubble is a NOP

	execUnit execute (.clock(clock), .rst(rst), .hold(hold), .op(exOp),
		.wbRd(wbOp.rd), .wbValue(wbOp.value), .wbWrite(wbOp.writesReg),
		.dataMode(dataMode), .dataAddr(dataAddr), .dataWrData(dataWrData),
		.dataRdData(dataRdData), .dataOk(dataOk), .result(resultNext),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .halted(halted));

	// the branch itself moves on, so the result stage never flushes
	pipeStage #(.payloadT(resultOp), .bubble('0)) wbStage (.clock(clock), .rst(rst),
		.hold(hold), .flush(1'b0), .d(resultNext), .q(wbOp));

	resultRegs regFile (.clock(clock), .rst(rst), .hold(hold), .res(wbOp),
		.raAddr(raAddr), .rbAddr(rbAddr), .raVal(raVal), .rbVal(rbVal));

endmodule

`default_nettype wire

// File: tinyPipe_properties.sv
`timescale 1ns/1ps
`include "tinyPipe_macros.svh"
`default_nettype none

module tinyPipe_properties (
	input logic clock,
	input logic rst,
	input tinyPipePkg::memMode mode,		// external request
	input logic [`PC_W-1:0] addr,
	input logic [`DATA_W-1:0] wrData,
	input tinyPipePkg::okCode ok,
	input logic halted
);
	import tinyPipePkg::*;

	// a held request comes back unchanged
	holdStable: assert property (@(posedge clock) disable iff (rst)
		ok == OK_HOLD |=> $stable(mode) && $stable(addr) && $stable(wrData))
		else $error("memory request changed while held");

	idleAfterReset: assert property (@(posedge clock) rst |=> mode == MEM_IDLE)
		else $error("memory port busy right after reset");

	// only reset clears halted
	haltSticky: assert property (@(posedge clock) $fell(halted) |-> $past(rst))
		else $error("halted fell without reset");

endmodule

bind tinyPipeTop tinyPipe_properties props (.clock(clock), .rst(rst), .mode(memMode),
	.addr(memAddr), .wrData(memWrData), .ok(memOk), .halted(halted));

`default_nettype wire

// File: tinyPipe_tb.sv
`timescale 1ns/1ps
`include "tinyPipe_macros.svh"
`default_nettype none

module tinyPipe_tb;
	import tinyPipePkg::*;

	localparam int PERIOD = 40;
	localparam int MEM_WORDS = 256;		// word addressed, index is memAddr[8:1]
	localparam int TIMEOUT = 3000;		// cycles allowed until halted
	localparam int MODEL_STEPS = 1000;

	logic clock = 1'b0;
	logic rst = 1'b1;
	tinyPipePkg::memMode busMode;
	logic [`PC_W-1:0] memAddr;
	logic [`DATA_W-1:0] memWrData;
	logic [`DATA_W-1:0] memRdData;
	okCode memOk;
	logic halted;

	logic [`DATA_W-1:0] mem [MEM_WORDS];		// DUT side memory
	logic [`DATA_W-1:0] image [MEM_WORDS];		// loaded into mem while in reset
	logic [`DATA_W-1:0] modelMem [MEM_WORDS];	// reference model memory
	logic [`DATA_W-1:0] prog [$];
	logic [15:0] lateWrites = '0;		// stores done after halted
	bit useWaits = 1'b0;
	logic waitNow = 1'b0;		// memory answers HOLD this cycle
	integer seed = 32'ha69dd8b9;
	int errors = 0;
	int testCount = 0;
	int failCount = 0;

	tinyPipeTop DUT (.clock(clock), .rst(rst), .memMode(busMode), .memAddr(memAddr),
		.memWrData(memWrData), .memRdData(memRdData), .memOk(memOk), .halted(halted));

	always #(PERIOD/2) clock = ~clock;

	// same-cycle answer, HOLD only on a live request
	assign memOk = (busMode == MEM_IDLE) ? OK_READY : (waitNow ? OK_HOLD : OK_OK);
	assign memRdData = mem[memAddr[8:1]];

	always @(negedge clock)
	begin
		waitNow <= useWaits && (($random(seed) & 3) == 0);	// about one cycle in four
	end

	always @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= image[i];		// fresh contents per program
			lateWrites <= '0;
		end
		else if (busMode == MEM_STORE && memOk == OK_OK)
		begin
			mem[memAddr[8:1]] <= memWrData;
			if (halted)
				lateWrites <= lateWrites + 16'd1;
		end
	end

	function automatic logic [15:0] fillWord(input int i);
		return {i[7:0], ~i[7:0]};		// unique per word
	endfunction

	function automatic logic [15:0] regOp(input opCode op, input int rd, input int ra,
		input int rb);
		return {op, rd[2:0], ra[2:0], rb[2:0], 3'b000};
	endfunction

	function automatic logic [15:0] immOp(input opCode op, input int rd, input int ra,
		input int imm);
		return {op, rd[2:0], ra[2:0], imm[5:0]};
	endfunction

	function automatic logic [15:0] jumpOp(input int imm);
		return {OP_BRA, 3'b000, imm[8:0]};
	endfunction

	task automatic checkValue(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// instruction set interpreter, one instruction per step
	task automatic runModel();
		logic [15:0] r [8];
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] imm;
		logic [15:0] ea;
		logic [7:0] pcw;
		logic [3:0] op;
		logic [2:0] rd;
		bit done;
		for (int i = 0; i < 8; i++)
			r[i] = 16'd0;
		for (int i = 0; i < MEM_WORDS; i++)
			modelMem[i] = image[i];
		pcw = 8'd0;
		done = 1'b0;
		for (int step = 0; step < MODEL_STEPS && !done; step++)
		begin
			ins = modelMem[pcw];
			op = ins[15:12];
			rd = ins[11:9];
			a = r[ins[8:6]];
			b = r[ins[5:3]];
			imm = {{10{ins[5]}}, ins[5:0]};
			ea = a + imm;		// word address for LD and ST
			pcw = pcw + 8'd1;
			case (op)
				OP_ADD: r[rd] = a + b;
				OP_SUB: r[rd] = a - b;
				OP_AND: r[rd] = a & b;
				OP_OR: r[rd] = a | b;
				OP_XOR: r[rd] = a ^ b;
				OP_SHL: r[rd] = a << b[3:0];
				OP_ADDI: r[rd] = ea;
				OP_LD: r[rd] = modelMem[ea[7:0]];
				OP_ST: modelMem[ea[7:0]] = r[rd];
				OP_BEQZ: if (r[rd] == 16'd0) pcw = pcw - 8'd1 + imm[7:0];
				OP_BRA: pcw = pcw - 8'd1 + ins[7:0];	// imm9 wraps in 256 words
				OP_HALT: done = 1'b1;
				default: ;		// NOP and unused opcodes
			endcase
			r[0] = 16'd0;
		end
		if (!done)
		begin
			$display("reference model ran %0d steps without reaching HALT", MODEL_STEPS);
			errors++;
		end
	endtask

	task automatic runProgram(input string name, input bit waits);
		int cyc;
		int errBefore;
		errBefore = errors;
		@(negedge clock);
		rst = 1'b1;
		useWaits = waits;
		for (int i = 0; i < MEM_WORDS; i++)
			image[i] = (i < prog.size()) ? prog[i] : fillWord(i);
		repeat (3) @(negedge clock);		// three reset edges
		rst = 1'b0;
		cyc = 0;
		while (!halted && cyc < TIMEOUT)
		begin
			@(negedge clock);
			cyc++;
		end
		if (!halted)
		begin
			$display("%s: halted did not rise within %0d cycles", name, TIMEOUT);
			errors++;
		end
		repeat (8) @(negedge clock);		// window for stray stores
		runModel();
		for (int i = 0; i < MEM_WORDS; i++)
			checkValue($sformatf("mem[%0d]", i), mem[i], modelMem[i]);
		checkValue("lateWrites", lateWrites, 16'd0);
		testCount++;
		if (errors != errBefore)
			failCount++;
		$display("%s: %s", name, (errors == errBefore) ? "pass" : "fail");
	endtask

	task automatic aluOps();
		prog.delete();
		prog.push_back(immOp(OP_ADDI, 1, 0, 13));
		prog.push_back(immOp(OP_ADDI, 2, 0, -6));
		prog.push_back(regOp(OP_ADD, 3, 1, 2));
		prog.push_back(regOp(OP_SUB, 4, 1, 2));
		prog.push_back(regOp(OP_AND, 5, 1, 2));
		prog.push_back(regOp(OP_OR, 6, 1, 2));
		prog.push_back(immOp(OP_ST, 3, 0, 16));
		prog.push_back(immOp(OP_ST, 4, 0, 17));
		prog.push_back(regOp(OP_XOR, 3, 1, 2));
		prog.push_back(regOp(OP_SHL, 4, 1, 1));
		prog.push_back(immOp(OP_ST, 5, 0, 18));
		prog.push_back(immOp(OP_ST, 6, 0, 19));
		prog.push_back(immOp(OP_ST, 3, 0, 20));
		prog.push_back(immOp(OP_ST, 4, 0, 21));
		prog.push_back(immOp(OP_HALT, 0, 0, 0));
		runProgram("ALU operations", 1'b0);
	endtask

	task automatic forwardChain();
		prog.delete();
		prog.push_back(immOp(OP_ADDI, 1, 0, 5));
		prog.push_back(regOp(OP_ADD, 2, 1, 1));		// distance one
		prog.push_back(regOp(OP_ADD, 3, 2, 1));		// r1 at distance two
		prog.push_back(regOp(OP_SUB, 4, 3, 2));
		prog.push_back(immOp(OP_ST, 4, 0, 22));
		prog.push_back(regOp(OP_XOR, 5, 4, 3));
		prog.push_back(immOp(OP_ADDI, 5, 5, 7));
		prog.push_back(immOp(OP_ST, 5, 0, 23));
		prog.push_back(immOp(OP_ST, 3, 0, 24));
		prog.push_back(immOp(OP_HALT, 0, 0, 0));
		runProgram("back-to-back dependencies", 1'b0);
	endtask

	task automatic loadThenUse(input bit waits);
		prog.delete();
		prog.push_back(immOp(OP_LD, 1, 0, 30));		// prefilled word
		prog.push_back(regOp(OP_ADD, 2, 1, 1));
		prog.push_back(immOp(OP_ST, 2, 0, 25));
		prog.push_back(immOp(OP_LD, 3, 0, 25));
		prog.push_back(immOp(OP_ST, 3, 0, 26));
		prog.push_back(immOp(OP_HALT, 0, 0, 0));
		runProgram(waits ? "load then use, wait states" : "load then use", waits);
	endtask

	task automatic branchSkips(input bit waits);
		prog.delete();
		prog.push_back(immOp(OP_ADDI, 1, 0, 7));
		prog.push_back(jumpOp(3));			// to word 4
		prog.push_back(immOp(OP_ST, 1, 0, 16));
		prog.push_back(immOp(OP_ST, 1, 0, 17));
		prog.push_back(immOp(OP_BEQZ, 0, 0, 3));	// r0 is zero, to word 7
		prog.push_back(immOp(OP_ST, 1, 0, 18));
		prog.push_back(immOp(OP_ST, 1, 0, 19));
		prog.push_back(immOp(OP_BEQZ, 1, 0, 3));	// falls through
		prog.push_back(immOp(OP_ST, 1, 0, 20));
		prog.push_back(immOp(OP_ST, 1, 0, 21));
		prog.push_back(immOp(OP_HALT, 0, 0, 0));
		runProgram(waits ? "branches, wait states" : "branches", waits);
	endtask

	task automatic haltStops();
		prog.delete();
		prog.push_back(immOp(OP_ADDI, 1, 0, 9));
		prog.push_back(immOp(OP_ST, 1, 0, 16));
		prog.push_back(immOp(OP_HALT, 0, 0, 0));
		prog.push_back(immOp(OP_ST, 1, 0, 17));		// already in the pipe
		prog.push_back(immOp(OP_ST, 1, 0, 18));
		prog.push_back(jumpOp(-5));
		runProgram("HALT", 1'b0);
	endtask

	initial
	begin
		aluOps();
		forwardChain();
		loadThenUse(1'b0);
		branchSkips(1'b0);
		loadThenUse(1'b1);
		branchSkips(1'b1);
		haltStops();
		$display("%0d tests run, %0d failed, %0d errors", testCount, failCount, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tinyPipe.f
+incdir+.
tinyPipePkg.sv
pipeStage.sv
instrDecode.sv
execUnit.sv
resultRegs.sv
memArbiter.sv
tinyPipeTop.sv
tinyPipe_properties.sv
tinyPipe_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tinyPipe_tb
FILELIST ?= tinyPipe.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
